// ==== test/mlse_vectors.txt ====
# Columns: op sample expected_valid expected_symbol
# op: 0 idle, 1 sample, 2 sample with noise added, 3 flush
0 0 0 0
0 0 0 0
1 20 0 0
1 20 0 0
1 -20 0 0
1 -40 1 1
1 0 1 0
1 20 1 -1
1 20 1 -1
0 0 0 0
3 0 0 0
2 -20 0 0
2 0 0 0
0 0 0 0
2 40 0 0
2 20 1 -1
0 0 0 0
2 -20 1 1
3 0 0 0
1 20 0 0
1 20 0 0
1 0 0 0
1 -20 1 1
0 0 0 0
1 0 1 0
0 0 0 0

// ==== mlse_detector.f ====
design/mlse_types_pkg.sv
design/mlse_ctrl_pkg.sv
design/select_two.sv
design/select_unit.sv
design/branch_metric.sv
design/path_memory.sv
design/mlse_detector.sv
test/mlse_detector_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -rf obj_dir "$LOG"
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module mlse_detector_tb -f mlse_detector.f -o mlse_sim > "$LOG" 2>&1 \
    && ./obj_dir/mlse_sim >> "$LOG" 2>&1 \
    || echo "Build or simulation ended with an error" >> "$LOG"
cat "$LOG"
grep -q "ALL TESTS PASSED" "$LOG" || exit 1
exit 0

// ==== test/mlse_detector_tb.sv ====
module mlse_detector_tb
    import mlse_types_pkg::*;
    import mlse_ctrl_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_VEC   = 256;
    localparam int NOISE_MAX = AMP / 4;   // Keeps the sent path the unique minimum

    logic     clk;
    logic     arst_n;
    rx_req_t  req;
    dec_rsp_t rsp;

    int vec_op  [MAX_VEC];    // 0 idle, 1 sample, 2 noisy sample, 3 flush
    int vec_smp [MAX_VEC];
    int vec_ev  [MAX_VEC];
    int vec_es  [MAX_VEC];
    int vec_cnt;
    int cycle;
    int cycle_limit = 1000;
    int run_cycles = 0;
    int seed = 32'h7b5805d7;
    int exp_sym_q [$];
    int exp_cyc_q [$];        // Cycle in which each response is due

    mlse_detector dut (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (req),
        .rsp    (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1, "Run stopped");
    endtask

    task automatic check_value(input logic signed [31:0] expected,
                               input logic signed [31:0] actual, input string msg);
        if (expected !== actual) begin
            $display("ERROR %0d ns: %s expected %0d got %0d", $time, msg, expected, actual);
            $display("SOME TESTS FAILED");
            $fatal(1, "Mismatch");
        end
    endtask

    always @(posedge clk) begin
        run_cycles++;
        if (run_cycles > cycle_limit) begin
            abort_run($sformatf("Timeout: the run did not finish within %0d cycles", cycle_limit));
        end
    end

    task automatic load_vectors();
        int    fd;
        int    n;
        string hdr;
        vec_cnt = 0;
        fd = $fopen("test/mlse_vectors.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open the vector file test/mlse_vectors.txt");
        end else begin
            repeat (2) begin
                void'($fgets(hdr, fd));   // Column description lines
            end
            while (vec_cnt < MAX_VEC) begin
                n = $fscanf(fd, "%d %d %d %d", vec_op[vec_cnt], vec_smp[vec_cnt],
                            vec_ev[vec_cnt], vec_es[vec_cnt]);
                if (n != 4) begin
                    break;
                end
                vec_cnt++;
            end
            $fclose(fd);
        end
    endtask

    // Outputs are sampled on the falling edge, half a cycle after they change
    task automatic check_outputs();
        if (exp_cyc_q.size() > 0 && exp_cyc_q[0] == cycle) begin
            check_value(1, rsp.valid, "response valid");
            check_value(exp_sym_q[0], rsp.symbol, "decided symbol");
            void'(exp_cyc_q.pop_front());
            void'(exp_sym_q.pop_front());
        end else if (rsp.valid !== 1'b0) begin
            abort_run($sformatf("A response came in cycle %0d when none was due", cycle));
        end
    endtask

    task automatic tick();
        @(negedge clk);
        cycle++;
        check_outputs();
    endtask

    task automatic drive_line(input int i);
        int noise;
        noise = 0;
        req   = '0;
        if (vec_op[i] == 1 || vec_op[i] == 2) begin
            if (vec_op[i] == 2) begin
                noise = $random(seed) % (NOISE_MAX + 1);
            end
            req.valid  = 1'b1;
            req.op     = OP_SAMPLE;
            req.sample = sample_t'(vec_smp[i] + noise);
        end else if (vec_op[i] == 3) begin
            req.valid = 1'b1;
            req.op    = OP_FLUSH;
        end
        if (vec_ev[i] != 0) begin
            exp_cyc_q.push_back(cycle + 2);   // Fixed two-cycle latency
            exp_sym_q.push_back(vec_es[i]);
        end
    endtask

    initial begin
        req    = '0;
        arst_n = 1'b0;
        cycle  = 0;
        load_vectors();
        cycle_limit = vec_cnt * 4 + 20;
        repeat (2) begin
            tick();
        end
        arst_n = 1'b1;
        for (int i = 0; i < vec_cnt; i++) begin
            tick();
            drive_line(i);
        end
        repeat (3) begin
            tick();
            req = '0;
        end
        if (vec_cnt > 0 && exp_cyc_q.size() == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            abort_run("No vectors were read or some expected responses never arrived");
        end
    end

endmodule

// ==== design/mlse_detector.sv ====
module mlse_detector
    import mlse_types_pkg::*;
    import mlse_ctrl_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  rx_req_t  req,
    output dec_rsp_t rsp
);

    energy_t [N_B-1:0][N_B-1:0] metrics;
    path_t   [N_B-1:0][N_B-1:0] cand;
    path_t   [N_B-1:0]          win;
    path_t   [N_B-1:0]          surv;
    path_t                      best;
    logic                       out_en;
    logic                       sample_d;    // Sample strobe one cycle late
    logic                       rsp_valid;
    symbol_t                    rsp_symbol;

    branch_metric u_bm (
        .sample  (req.sample),
        .metrics (metrics)
    );

    path_memory u_pm (
        .clk     (clk),
        .arst_n  (arst_n),
        .req     (req),
        .metrics (metrics),
        .win     (win),
        .cand    (cand),
        .surv    (surv),
        .out_en  (out_en)
    );

    // Add-compare-select, one unit per new state
    for (genvar s = 0; s < N_B; s++) begin : g_acs
        select_unit #(
            .N (N_B)
        ) acs_i (
            .paths (cand[s]),
            .best  (win[s])
        );
    end

    select_unit #(
        .N (N_B)
    ) best_i (
        .paths (surv),
        .best  (best)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sample_d  <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            sample_d  <= req.valid && (req.op == OP_SAMPLE);
            rsp_valid <= sample_d && out_en;
        end
    end

    always_ff @(posedge clk) begin
        if (sample_d) begin
            rsp_symbol <= best.history[H_DEPTH-1];   // Oldest entry of best path
        end
    end

    assign rsp = '{valid: rsp_valid, symbol: rsp_symbol};

endmodule

// ==== design/path_memory.sv ====
module path_memory
    import mlse_types_pkg::*;
    import mlse_ctrl_pkg::*;
(
    input  logic                              clk,
    input  logic                              arst_n,
    input  rx_req_t                           req,
    input  energy_t [N_B-1:0][N_B-1:0]        metrics,
    input  path_t   [N_B-1:0]                 win,
    output path_t   [N_B-1:0][N_B-1:0]        cand,
    output path_t   [N_B-1:0]                 surv,
    output logic                              out_en
);

    fill_state_e       state;
    logic [FILL_W-1:0] fill_cnt;
    energy_t           win_min;
    logic              surv_has_zero;

    function automatic energy_t sat_add(energy_t x, energy_t y);
        logic [E_WIDTH:0] sum;
        sum = {1'b0, x} + {1'b0, y};
        return sum[E_WIDTH] ? E_MAX : sum[E_WIDTH-1:0];
    endfunction

    // Only the state of previous symbol 0 starts as a valid origin
    function automatic path_t flush_path(int s);
        path_t p;
        p.energy  = (state_symbol(s) == 0) ? '0 : E_MAX;
        p.history = '0;
        return p;
    endfunction

    always_comb begin
        for (int s = 0; s < N_B; s++) begin
            for (int p = 0; p < N_B; p++) begin
                cand[s][p].energy  = sat_add(surv[p].energy, metrics[s][p]);
                cand[s][p].history = {surv[p].history[H_DEPTH-2:0], state_symbol(s)};
            end
        end
    end

    always_comb begin
        win_min = win[0].energy;
        for (int s = 1; s < N_B; s++) begin
            if (win[s].energy < win_min) begin
                win_min = win[s].energy;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= ST_FILL;
            fill_cnt <= '0;
            for (int s = 0; s < N_B; s++) begin
                surv[s] <= flush_path(s);
            end
        end else if (req.valid) begin
            case (req.op)
                OP_FLUSH: begin
                    state    <= ST_FILL;
                    fill_cnt <= '0;
                    for (int s = 0; s < N_B; s++) begin
                        surv[s] <= flush_path(s);
                    end
                end
                default: begin
                    for (int s = 0; s < N_B; s++) begin
                        surv[s].energy  <= win[s].energy - win_min;   // Normalise
                        surv[s].history <= win[s].history;
                    end
                    if (fill_cnt == FILL_MAX) begin
                        state <= ST_RUN;
                    end else begin
                        fill_cnt <= fill_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    assign out_en = (state == ST_RUN);

    always_comb begin
        surv_has_zero = 1'b0;
        for (int s = 0; s < N_B; s++) begin
            surv_has_zero = surv_has_zero | (surv[s].energy == '0);
        end
    end

    a_norm_zero: assert property (@(posedge clk) disable iff (!arst_n)
        $past(req.valid) |-> surv_has_zero);

    a_run_filled: assert property (@(posedge clk) disable iff (!arst_n)
        (state == ST_RUN) |-> (fill_cnt == FILL_MAX));

endmodule

// ==== design/branch_metric.sv ====
module branch_metric
    import mlse_types_pkg::*;
(
    input  sample_t                      sample,
    output energy_t [N_B-1:0][N_B-1:0]   metrics
);

    // Element [s][p] compares against AMP * (symbol s + symbol p)
    for (genvar s = 0; s < N_B; s++) begin : g_new
        for (genvar p = 0; p < N_B; p++) begin : g_prev
            logic signed [D_WIDTH-1:0] level;
            logic signed [D_WIDTH-1:0] diff;
            logic [2*D_WIDTH-1:0]      sq;

            assign level = D_WIDTH'(AMP * (int'(state_symbol(s)) + int'(state_symbol(p))));
            assign diff  = D_WIDTH'(sample) - level;
            assign sq    = diff * diff;

            always_comb begin
                if (sq > (2*D_WIDTH)'(E_MAX)) begin
                    metrics[s][p] = E_MAX;           // Clip wide errors
                end else begin
                    metrics[s][p] = sq[E_WIDTH-1:0];
                end
            end
        end
    end

endmodule

// ==== design/select_unit.sv ====
module select_unit
    import mlse_types_pkg::*;
#(
    parameter int N = N_B
) (
    input  path_t [N-1:0] paths,
    output path_t         best
);

    localparam int LEVELS = $clog2(N);
    localparam int LEAVES = 1 << LEVELS;

    // Level 0 holds the padded leaves, level LEVELS the single winner
    for (genvar l = 0; l <= LEVELS; l++) begin : g_lvl
        path_t [(LEAVES >> l)-1:0] node;

        if (l == 0) begin : g_leaf
            for (genvar i = 0; i < LEAVES; i++) begin : g_in
                if (i < N) begin : g_real
                    assign node[i] = paths[i];
                end else begin : g_pad
                    assign node[i] = '{energy: E_MAX, history: '0};
                end
            end
        end else begin : g_red
            for (genvar i = 0; i < (LEAVES >> l); i++) begin : g_pair
                select_two u_sel (
                    .a (g_lvl[l-1].node[2*i]),      // Lower index on a
                    .b (g_lvl[l-1].node[2*i+1]),
                    .y (node[i])
                );
            end
        end
    end

    assign best = g_lvl[LEVELS].node[0];

    // The tree never returns something worse than its first candidate.
    // Clocked on input changes since the unit has no clock of its own
    property p_best_not_worse;
        @(paths) $isunknown(paths) || (best.energy <= paths[0].energy);
    endproperty

    a_best_not_worse: assert property (p_best_not_worse);

endmodule

// ==== design/select_two.sv ====
module select_two
    import mlse_types_pkg::*;
(
    input  path_t a,
    input  path_t b,
    output path_t y
);

    logic b_lower;

    assign b_lower = (b.energy < a.energy);   // Strict, so a wins a tie

    always_comb begin
        if (b_lower) begin
            y = b;
        end else begin
            y = a;
        end
    end

endmodule

// ==== design/mlse_ctrl_pkg.sv ====
package mlse_ctrl_pkg;

    localparam int FILL_W = $clog2(mlse_types_pkg::H_DEPTH);           // Fill counter width
    localparam logic [FILL_W-1:0] FILL_MAX = FILL_W'(mlse_types_pkg::H_DEPTH - 1);

    typedef enum logic {
        OP_SAMPLE = 1'b0,
        OP_FLUSH  = 1'b1
    } op_e;

    typedef enum logic {
        ST_FILL = 1'b0,    // Histories not yet deep enough
        ST_RUN  = 1'b1
    } fill_state_e;

    typedef struct packed {
        logic                     valid;
        op_e                      op;
        mlse_types_pkg::sample_t  sample;
    } rx_req_t;

    typedef struct packed {
        logic                     valid;
        mlse_types_pkg::symbol_t  symbol;
    } dec_rsp_t;

endpackage

// ==== design/mlse_types_pkg.sv ====
package mlse_types_pkg;

    localparam int B_WIDTH = 8;              // Received sample width
    localparam int E_WIDTH = 2 * B_WIDTH;    // Path energy width
    localparam int D_WIDTH = B_WIDTH + 2;    // Sample minus widest reference level
    localparam int N_B     = 3;              // One state per previous symbol
    localparam int H_DEPTH = 4;              // Survivor history depth
    localparam int AMP     = 20;             // Channel gain

    typedef logic signed [B_WIDTH-1:0] sample_t;
    typedef logic [E_WIDTH-1:0] energy_t;
    typedef logic signed [1:0] symbol_t;

    localparam energy_t E_MAX = '1;          // Padding and saturation value

    // Index 0 holds the newest symbol
    typedef symbol_t [H_DEPTH-1:0] history_t;

    typedef struct packed {
        energy_t  energy;
        history_t history;
    } path_t;

    // Trellis states 0, 1, 2 stand for symbols -1, 0, +1
    function automatic symbol_t state_symbol(int s);
        return symbol_t'(s - 1);
    endfunction

endpackage
